// ==== hw/udp_tx_pkg.sv ====
// header structs, header byte view, stream beat and protocol sizes for the udp transmitter

package udp_tx_pkg;

    // fixed protocol sizes in bytes
    localparam int unsigned UDP_HDR_BYTES = 8;
    localparam int unsigned IP_HDR_BYTES  = 20;

    // ip header fields that travel with the udp header, no length
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] source_ip;
        logic [31:0] dest_ip;
    } ip_hdr_t;

    // output form, length filled in by the transmitter
    typedef struct packed {
        ip_hdr_t     ip;
        logic [15:0] ip_length;
    } ip_hdr_full_t;

    typedef struct packed {
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // bytes[0] is the most significant byte, sent first on the wire
    typedef union packed {
        udp_hdr_t                             fields;
        logic [0:UDP_HDR_BYTES-1][7:0]        bytes;
    } udp_hdr_u;

    // one byte of the payload stream with its sideband bits
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       last;
        logic       user;
    } stream_beat_t;

endpackage

// ==== hw/ip_hdr_out.sv ====
// ip header output register with valid/ready handshake and ip length computation

`timescale 1ns/1ps

module ip_hdr_out (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hdr_store,
    input  udp_tx_pkg::ip_hdr_t      in_ip,
    input  logic [15:0]              udp_length,
    output udp_tx_pkg::ip_hdr_full_t out_hdr,
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output logic                     hdr_pending
);
    import udp_tx_pkg::*;

    // a header is still owed downstream next cycle if stored now or not yet taken
    assign hdr_pending = hdr_store || (out_hdr_valid && !out_hdr_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_hdr_valid <= 1'b0;
        end else begin
            out_hdr_valid <= hdr_pending;
        end

        // header fields only change on a new accept
        if (hdr_store) begin
            out_hdr.ip        <= in_ip;
            out_hdr.ip_length <= udp_length + 16'(IP_HDR_BYTES);
        end
    end

endmodule

// ==== hw/udp_frame_ctrl.sv ====
// frame FSM: udp header serializer, payload pass-through and udp length check

`timescale 1ns/1ps

module udp_frame_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  udp_tx_pkg::udp_hdr_t     in_udp,
    output logic                     hdr_store,
    input  logic                     hdr_pending,
    input  logic [7:0]               in_data,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     in_last,
    input  logic                     in_user,
    output udp_tx_pkg::stream_beat_t beat,
    input  logic                     buf_ready,
    input  logic                     buf_ready_early,
    output logic                     busy,
    output logic                     error_early_end
);
    import udp_tx_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_PAYLOAD_LAST
    } state_t;

    localparam logic [2:0] HDR_PTR_LAST = 3'(UDP_HDR_BYTES - 1);

    state_t      state;
    state_t      state_next;
    udp_hdr_u    udp_q;
    logic [2:0]  hdr_ptr;
    logic [2:0]  hdr_ptr_next;
    logic [15:0] remain;
    logic [15:0] remain_next;
    logic [7:0]  last_data;
    logic        store_last;
    logic        hdr_ready_next;
    logic        in_ready_next;
    logic        error_next;
    logic        in_xfer;

    assign in_xfer = in_valid && in_ready;

    always_comb begin
        state_next     = state;
        hdr_ready_next = 1'b0;
        in_ready_next  = 1'b0;
        hdr_store      = 1'b0;
        store_last     = 1'b0;
        hdr_ptr_next   = hdr_ptr;
        remain_next    = remain;
        error_next     = 1'b0;
        beat           = '0;

        case (state)
            ST_IDLE: begin
                hdr_ptr_next   = '0;
                hdr_ready_next = !hdr_pending;
                if (hdr_valid && hdr_ready) begin
                    hdr_store      = 1'b1;
                    hdr_ready_next = 1'b0;
                    remain_next    = in_udp.length - 16'(UDP_HDR_BYTES);
                    // first header byte can leave straight away
                    if (buf_ready) begin
                        beat.valid   = 1'b1;
                        beat.data    = in_udp.source_port[15:8];
                        hdr_ptr_next = 3'd1;
                    end
                    state_next = ST_HEADER;
                end
            end

            ST_HEADER: begin
                if (buf_ready) begin
                    beat.valid   = 1'b1;
                    beat.data    = udp_q.bytes[hdr_ptr];
                    hdr_ptr_next = hdr_ptr + 3'd1;
                    if (hdr_ptr == HDR_PTR_LAST) begin
                        in_ready_next = buf_ready_early;
                        state_next    = ST_PAYLOAD;
                    end
                end
            end

            ST_PAYLOAD: begin
                in_ready_next = buf_ready_early;
                beat.data     = in_data;
                beat.valid    = in_xfer;
                beat.last     = in_last;
                beat.user     = in_user;
                if (in_xfer) begin
                    remain_next = remain - 16'd1;
                    if (in_last) begin
                        // frame ended short of the udp length
                        if (remain != 16'd1) begin
                            beat.user  = 1'b1;
                            error_next = 1'b1;
                        end
                        hdr_ready_next = !hdr_pending;
                        in_ready_next  = 1'b0;
                        state_next     = ST_IDLE;
                    end else if (remain == 16'd1) begin
                        // hold the boundary byte until tlast shows up
                        store_last = 1'b1;
                        beat.valid = 1'b0;
                        state_next = ST_PAYLOAD_LAST;
                    end
                end
            end

            ST_PAYLOAD_LAST: begin
                // surplus bytes are read and dropped
                in_ready_next = buf_ready_early;
                beat.data     = last_data;
                beat.valid    = in_xfer && in_last;
                beat.last     = in_last;
                beat.user     = in_user;
                if (in_xfer && in_last) begin
                    hdr_ready_next = !hdr_pending;
                    in_ready_next  = 1'b0;
                    state_next     = ST_IDLE;
                end
            end

            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= ST_IDLE;
            hdr_ready       <= 1'b0;
            in_ready        <= 1'b0;
            busy            <= 1'b0;
            error_early_end <= 1'b0;
            hdr_ptr         <= '0;
            remain          <= '0;
        end else begin
            state           <= state_next;
            hdr_ready       <= hdr_ready_next;
            in_ready        <= in_ready_next;
            busy            <= (state_next != ST_IDLE);
            error_early_end <= error_next;
            hdr_ptr         <= hdr_ptr_next;
            remain          <= remain_next;
        end

        if (hdr_store) begin
            udp_q.fields <= in_udp;
        end

        if (store_last) begin
            last_data <= in_data;
        end
    end

endmodule

// ==== hw/byte_skid_buf.sv ====
// two-entry output register stage for the byte stream with registered ready

`timescale 1ns/1ps

module byte_skid_buf (
    input  logic                     clk,
    input  logic                     rst,
    input  udp_tx_pkg::stream_beat_t beat,
    output logic                     buf_ready,
    output logic                     buf_ready_early,
    output logic [7:0]               out_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_last,
    output logic                     out_user
);
    import udp_tx_pkg::*;

    stream_beat_t out_q;
    stream_beat_t tmp_q;
    logic         to_out;
    logic         to_tmp;
    logic         tmp_to_out;

    // ready next cycle unless the temp register would fill up
    assign buf_ready_early = out_ready || (!tmp_q.valid && (!out_q.valid || !beat.valid));

    always_comb begin
        to_out     = 1'b0;
        to_tmp     = 1'b0;
        tmp_to_out = 1'b0;
        if (buf_ready) begin
            if (out_ready || !out_q.valid) begin
                to_out = 1'b1;
            end else begin
                to_tmp = 1'b1;
            end
        end else if (out_ready) begin
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_ready   <= 1'b0;
            out_q.valid <= 1'b0;
            tmp_q.valid <= 1'b0;
        end else begin
            buf_ready <= buf_ready_early;
            if (to_out) begin
                out_q.valid <= beat.valid;
            end else if (tmp_to_out) begin
                out_q.valid <= tmp_q.valid;
            end
            if (to_tmp) begin
                tmp_q.valid <= beat.valid;
            end else if (tmp_to_out) begin
                tmp_q.valid <= 1'b0;
            end
        end

        // payload bits
        if (to_out) begin
            out_q.data <= beat.data;
            out_q.last <= beat.last;
            out_q.user <= beat.user;
        end else if (tmp_to_out) begin
            out_q.data <= tmp_q.data;
            out_q.last <= tmp_q.last;
            out_q.user <= tmp_q.user;
        end
        if (to_tmp) begin
            tmp_q.data <= beat.data;
            tmp_q.last <= beat.last;
            tmp_q.user <= beat.user;
        end
    end

    assign out_data  = out_q.data;
    assign out_valid = out_q.valid;
    assign out_last  = out_q.last;
    assign out_user  = out_q.user;

endmodule

// ==== hw/udp_ip_tx.sv ====
// udp transmitter top: frame controller, ip header output and output skid buffer

`timescale 1ns/1ps

module udp_ip_tx (
    input  logic                     clk,
    input  logic                     rst,

    // udp header with its ip fields
    input  logic                     hdr_valid,
    output logic                     hdr_ready,
    input  udp_tx_pkg::ip_hdr_t      in_ip,
    input  udp_tx_pkg::udp_hdr_t     in_udp,

    // udp payload in
    input  logic [7:0]               in_data,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     in_last,
    input  logic                     in_user,

    // ip header out
    output logic                     out_hdr_valid,
    input  logic                     out_hdr_ready,
    output udp_tx_pkg::ip_hdr_full_t out_hdr,

    // ip payload out
    output logic [7:0]               out_data,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic                     out_last,
    output logic                     out_user,

    output logic                     busy,
    output logic                     error_early_end
);
    import udp_tx_pkg::*;

    stream_beat_t beat;
    logic         hdr_store;
    logic         hdr_pending;
    logic         buf_ready;
    logic         buf_ready_early;

    udp_frame_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .hdr_valid       (hdr_valid),
        .hdr_ready       (hdr_ready),
        .in_udp          (in_udp),
        .hdr_store       (hdr_store),
        .hdr_pending     (hdr_pending),
        .in_data         (in_data),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .in_last         (in_last),
        .in_user         (in_user),
        .beat            (beat),
        .buf_ready       (buf_ready),
        .buf_ready_early (buf_ready_early),
        .busy            (busy),
        .error_early_end (error_early_end)
    );

    ip_hdr_out u_hdr (
        .clk           (clk),
        .rst           (rst),
        .hdr_store     (hdr_store),
        .in_ip         (in_ip),
        .udp_length    (in_udp.length),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .hdr_pending   (hdr_pending)
    );

    byte_skid_buf u_buf (
        .clk             (clk),
        .rst             (rst),
        .beat            (beat),
        .buf_ready       (buf_ready),
        .buf_ready_early (buf_ready_early),
        .out_data        (out_data),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_last        (out_last),
        .out_user        (out_user)
    );

endmodule

// ==== testbench/udp_ip_tx_chk.sv ====
// concurrent protocol assertions on the udp transmitter outputs, bound to the top level

`timescale 1ns/1ps

module udp_ip_tx_chk (
    input logic                     clk,
    input logic                     rst,
    input logic [7:0]               out_data,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic                     out_last,
    input logic                     out_user,
    input logic                     out_hdr_valid,
    input logic                     out_hdr_ready,
    input udp_tx_pkg::ip_hdr_full_t out_hdr,
    input logic                     error_early_end
);

    // number of failed assertions so far
    int unsigned fail_count = 0;

    // a stalled byte stays put
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
            && $stable(out_last) && $stable(out_user))
        else begin
            $error("output byte dropped or changed while out_ready was low");
            fail_count++;
        end

    // header held until taken
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        out_hdr_valid && !out_hdr_ready |=> out_hdr_valid && $stable(out_hdr))
        else begin
            $error("ip header dropped or changed while out_hdr_ready was low");
            fail_count++;
        end

    error_pulse: assert property (@(posedge clk) disable iff (rst)
        error_early_end |=> !error_early_end)
        else begin
            $error("error_early_end lasted more than one cycle");
            fail_count++;
        end

endmodule

bind udp_ip_tx udp_ip_tx_chk u_chk (.*);

// ==== testbench/tb_udp_ip_tx.sv ====
// testbench for the udp transmitter: frame table, expected byte model and checks

`timescale 1ns/1ps

module tb_udp_ip_tx;
    import udp_tx_pkg::*;

    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_ROWS   = 8;

    typedef struct {
        string       name;
        udp_hdr_t    udp;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        int          n;
        logic        user;
        logic        rnd;
    } frame_row_t;

    logic         clk = 1'b0;
    logic         rst = 1'b1;
    logic         hdr_valid = 1'b0;
    logic         hdr_ready;
    ip_hdr_t      in_ip = '0;
    udp_hdr_t     in_udp = '0;
    logic [7:0]   in_data = '0;
    logic         in_valid = 1'b0;
    logic         in_ready;
    logic         in_last = 1'b0;
    logic         in_user = 1'b0;
    logic         out_hdr_valid;
    logic         out_hdr_ready = 1'b0;
    ip_hdr_full_t out_hdr;
    logic [7:0]   out_data;
    logic         out_valid;
    logic         out_ready = 1'b0;
    logic         out_last;
    logic         out_user;
    logic         busy;
    logic         error_early_end;

    frame_row_t   rows [NUM_ROWS];
    logic [9:0]   exp_q [$];
    logic [9:0]   got_q [$];
    ip_hdr_full_t hdr_q [$];
    int           err_pulses = 0;
    logic         rnd_mode = 1'b0;
    logic [31:0]  lcg_state = 32'hc0bf;

    udp_ip_tx dut (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic ip_hdr_t make_ip(input frame_row_t r, input int f);
        ip_hdr_t ip;
        ip                 = '0;
        ip.version         = 4'd4;
        ip.ihl             = 4'd5;
        ip.dscp            = 6'(f);
        ip.identification  = 16'(f * 16'h0111 + 16'h0a00);
        ip.flags           = 3'b010;
        ip.ttl             = 8'd64;
        ip.protocol        = 8'd17;
        ip.header_checksum = r.src_ip[15:0] ^ r.dst_ip[15:0];
        ip.source_ip       = r.src_ip;
        ip.dest_ip         = r.dst_ip;
        return ip;
    endfunction

    function automatic logic [7:0] payload_byte(input int f, input int i);
        return 8'(f * 49 + i * 7 + 90);
    endfunction

    task automatic fail_run(input string msg);
        $display("Result: FAILED");
        $fatal(1, "%s", msg);
    endtask

    task automatic check_eq(input string name, input logic [171:0] exp, input logic [171:0] act);
        assert (exp === act)
        else fail_run($sformatf("** Error: %s expected %0h actual %0h", name, exp, act));
    endtask

    // name, udp header, source ip, dest ip, payload bytes, last tuser, random ready
    task automatic load_table();
        rows[0] = '{"exact", '{16'h1234, 16'h0050, 16'd20, 16'habcd},
                    32'hc0a8_0001, 32'hc0a8_0002, 12, 1'b0, 1'b0};
        rows[1] = '{"exact_one", '{16'h8001, 16'h0035, 16'd9, 16'h0000},
                    32'h0a00_0001, 32'h0a00_00fe, 1, 1'b1, 1'b0};
        rows[2] = '{"short", '{16'hbeef, 16'h1f90, 16'd30, 16'h5a5a},
                    32'hac10_0203, 32'hac10_0909, 5, 1'b0, 1'b0};
        rows[3] = '{"long", '{16'h4321, 16'h0443, 16'd16, 16'h0f0f},
                    32'h7f00_0001, 32'h7f00_0002, 13, 1'b1, 1'b0};
        rows[4] = '{"exact_bp", '{16'h1234, 16'h0050, 16'd20, 16'habcd},
                    32'hc0a8_0001, 32'hc0a8_0002, 12, 1'b0, 1'b1};
        rows[5] = '{"short_bp", '{16'hface, 16'hd00d, 16'd40, 16'h1357},
                    32'h0102_0304, 32'h0506_0708, 17, 1'b0, 1'b1};
        rows[6] = '{"long_bp", '{16'h0007, 16'h0009, 16'd12, 16'hffff},
                    32'hdead_0001, 32'hbeef_0002, 9, 1'b0, 1'b1};
        rows[7] = '{"long_one_bp", '{16'h00aa, 16'h0055, 16'd9, 16'h1234},
                    32'h0a0a_0a0a, 32'h0b0b_0b0b, 4, 1'b1, 1'b1};
    endtask

    task automatic send_header(input int f);
        int cnt;
        cnt       = 0;
        in_ip     = make_ip(rows[f], f);
        in_udp    = rows[f].udp;
        hdr_valid = 1'b1;
        do begin
            @(posedge clk);
            cnt++;
            assert (cnt < WAIT_LIMIT) else fail_run("timeout waiting for hdr_ready");
        end while (!hdr_ready);
        #0.5;
        hdr_valid = 1'b0;
        check_eq({rows[f].name, " busy after header"}, 1, busy);
    endtask

    task automatic send_payload(input int f);
        int cnt;
        for (int i = 0; i < rows[f].n; i++) begin
            in_valid = 1'b1;
            in_data  = payload_byte(f, i);
            in_last  = (i == rows[f].n - 1);
            in_user  = in_last ? rows[f].user : 1'b0;
            cnt      = 0;
            do begin
                @(posedge clk);
                cnt++;
                assert (cnt < WAIT_LIMIT) else fail_run("timeout waiting for in_ready");
            end while (!in_ready);
            #0.5;
        end
        in_valid = 1'b0;
        in_last  = 1'b0;
        in_user  = 1'b0;
        check_eq({rows[f].name, " busy after last input"}, 0, busy);
    endtask

    task automatic run_frame(input int f);
        logic [63:0]  hdr64;
        int           plen;
        int           keep;
        int           cnt;
        logic         last;
        ip_hdr_full_t exp_hdr;
        @(posedge clk);
        #0.5;
        exp_q.delete();
        got_q.delete();
        hdr_q.delete();
        err_pulses = 0;
        rnd_mode   = rows[f].rnd;
        check_eq({rows[f].name, " idle before frame"}, 0, busy);

        // header bytes go out most significant first
        hdr64 = {rows[f].udp.source_port, rows[f].udp.dest_port,
                 rows[f].udp.length, rows[f].udp.checksum};
        for (int k = 0; k < 8; k++) begin
            exp_q.push_back({2'b00, hdr64[63 - 8 * k -: 8]});
        end
        plen = int'(rows[f].udp.length) - 8;
        keep = (rows[f].n < plen) ? rows[f].n : plen;
        for (int i = 0; i < keep; i++) begin
            last = (i == keep - 1);
            exp_q.push_back({last, last && (rows[f].n < plen || rows[f].user),
                             payload_byte(f, i)});
        end
        exp_hdr.ip        = make_ip(rows[f], f);
        exp_hdr.ip_length = rows[f].udp.length + 16'd20;

        send_header(f);
        send_payload(f);
        cnt = 0;
        while (got_q.size() < exp_q.size() || hdr_q.size() < 1) begin
            @(negedge clk);
            cnt++;
            assert (cnt < WAIT_LIMIT) else fail_run("timeout waiting for output bytes");
        end
        // room for the error pulse and any stray byte
        repeat (4) @(negedge clk);

        check_eq({rows[f].name, " byte count"}, exp_q.size(), got_q.size());
        foreach (exp_q[i]) begin
            check_eq($sformatf("%s byte %0d", rows[f].name, i), exp_q[i], got_q[i]);
        end
        check_eq({rows[f].name, " header count"}, 1, hdr_q.size());
        check_eq({rows[f].name, " ip header"}, exp_hdr, hdr_q[0]);
        check_eq({rows[f].name, " error pulses"}, (rows[f].n < plen) ? 1 : 0, err_pulses);
    endtask

    // output side ready, random in back-pressure rows
    always @(posedge clk) begin
        #0.5;
        lcg_state = lcg_next(lcg_state);
        if (rnd_mode) begin
            out_ready     = lcg_state[28];
            out_hdr_ready = lcg_state[19];
        end else begin
            out_ready     = 1'b1;
            out_hdr_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                got_q.push_back({out_last, out_user, out_data});
            end
            if (out_hdr_valid && out_hdr_ready) begin
                hdr_q.push_back(out_hdr);
            end
            if (error_early_end) begin
                err_pulses++;
            end
        end
    end

    // protocol assertions of the bound checker
    always @(negedge clk) begin
        assert (dut.u_chk.fail_count == 0)
        else fail_run("a protocol assertion in the bound checker failed");
    end

    initial begin
        load_table();
        repeat (10) @(posedge clk);
        #0.5;
        rst = 1'b0;
        check_eq("after reset", 6'b0,
                 {busy, hdr_ready, in_ready, out_valid, out_hdr_valid, error_early_end});
        for (int f = 0; f < NUM_ROWS; f++) begin
            run_frame(f);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== all.f ====
hw/udp_tx_pkg.sv
hw/ip_hdr_out.sv
hw/udp_frame_ctrl.sv
hw/byte_skid_buf.sv
hw/udp_ip_tx.sv
testbench/udp_ip_tx_chk.sv
testbench/tb_udp_ip_tx.sv
